//--- Makefile
# Verilator build and run for the envelope generator testbench

SRCS := $(shell cat flist.f)

all: run

# rebuilt only when a source or the file list changes
obj_dir/Veg_tb: flist.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module eg_tb -Mdir obj_dir -f flist.f

# pass only if the log holds the pass line
run: obj_dir/Veg_tb
	./obj_dir/Veg_tb | tee sim.log
	grep -qx "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

//--- flist.f
verilog/eg_pkg.sv
verilog/eg_counter.sv
verilog/eg_slot_ring.sv
verilog/eg_phase_ctrl.sv
verilog/eg_step.sv
verilog/eg_attenuate.sv
verilog/eg_top.sv
sim/eg_tb.sv

//--- sim/eg_tb.sv
// envelope generator testbench with slot rotation stimulus, per-slot reference model and compare
module eg_tb;

	localparam int NUM_SLOTS = 6;

	logic                    clk, reset, clk_en, zero, keyon;
	logic [4:0]              arate, d1rate, d2rate, keycode;
	logic [3:0]              rrate, sl;
	logic [1:0]              ks;
	logic [6:0]              tl;
	logic [eg_pkg::EG_W-1:0] eg_out;
	logic                    out_zero, pg_rst;

	// slot attributes as the driver presents them
	logic       s_key [NUM_SLOTS];
	logic [4:0] s_ar [NUM_SLOTS], s_d1 [NUM_SLOTS], s_d2 [NUM_SLOTS], s_kc [NUM_SLOTS];
	logic [3:0] s_rr [NUM_SLOTS], s_sl [NUM_SLOTS];
	logic [1:0] s_ks [NUM_SLOTS];
	logic [6:0] s_tl [NUM_SLOTS];

	// reference model state
	eg_pkg::eg_phase_t        m_phase [NUM_SLOTS];
	int                       m_level [NUM_SLOTS];
	logic                     m_key [NUM_SLOTS];
	logic [eg_pkg::CNT_W-1:0] m_cnt;

	// expected values in flight with eg_out two edges behind pg_rst
	logic [eg_pkg::EG_W-1:0] q_out [$];
	logic                    q_zero [$], q_pg [$];
	int                      q_slot [$], q_pg_slot [$];
	int                      errors, checks, pg_count, en_phase;

	eg_top #(.NUM_SLOTS(NUM_SLOTS)) u_eg_top (
		.clk(clk), .reset(reset), .clk_en(clk_en), .zero(zero), .keyon(keyon),
		.arate(arate), .d1rate(d1rate), .d2rate(d2rate), .rrate(rrate), .sl(sl),
		.keycode(keycode), .ks(ks), .tl(tl), .eg_out(eg_out), .out_zero(out_zero),
		.pg_rst(pg_rst));

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////
	function automatic logic [eg_pkg::EG_W-1:0] ref_eval(input int s, output logic pg);
		eg_pkg::eg_phase_t ph;
		logic              on_edge, off_edge;
		int                lvl, sl_lvl, base, rate, shift, dec, sum;
		if (s == 0) m_cnt = m_cnt + 1'b1;	// counter ticks with slot 0
		on_edge  = s_key[s] && !m_key[s];
		off_edge = !s_key[s] && m_key[s];
		sl_lvl   = (s_sl[s] == 4'd15) ? 1023 : int'(s_sl[s]) * 32;
		ph       = m_phase[s];
		lvl      = m_level[s];
		if (on_edge) begin
			ph = eg_pkg::PH_ATTACK;
			if (s_ar[s] == 5'd31) lvl = 0;
		end else if (off_edge) ph = eg_pkg::PH_RELEASE;
		else if (ph == eg_pkg::PH_ATTACK && lvl == 0) ph = eg_pkg::PH_DECAY;
		else if (ph == eg_pkg::PH_DECAY && lvl >= sl_lvl) ph = eg_pkg::PH_SUSTAIN;
		case (ph)
			eg_pkg::PH_ATTACK:  base = int'(s_ar[s]);
			eg_pkg::PH_DECAY:   base = int'(s_d1[s]);
			eg_pkg::PH_SUSTAIN: base = int'(s_d2[s]);
			default:            base = 2 * int'(s_rr[s]) + 1;
		endcase
		rate = (base == 0) ? 0 : 2 * base + (int'(s_kc[s]) >> (3 - int'(s_ks[s])));
		if (rate > 63) rate = 63;
		shift = 11 - rate / 4;
		if (shift < 0) shift = 0;
		if (rate != 0 && (int'(m_cnt) % (1 << shift)) == 0) begin
			if (ph == eg_pkg::PH_ATTACK) begin
				dec = lvl / 16 + 1;
				lvl = (lvl > dec) ? lvl - dec : 0;
			end else if (lvl < 1023) lvl = lvl + 1;
		end
		m_phase[s] = ph;
		m_level[s] = lvl;
		m_key[s]   = s_key[s];
		pg         = on_edge;
		sum        = lvl + 8 * int'(s_tl[s]);	// tl in steps of 8
		return (sum > 1023) ? eg_pkg::EG_MAX : eg_pkg::EG_W'(sum);
	endfunction

	//////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////
	task automatic check_level(input string name, input int slot,
			input logic [eg_pkg::EG_W-1:0] got, input logic [eg_pkg::EG_W-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %s slot %0d: got %h exp %h at %0t", name, slot, got, exp, $time);
		end
	endtask

	task automatic check_strobe(input string name, input int slot, input logic got,
			input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %s slot %0d: got %h exp %h at %0t", name, slot, got, exp, $time);
		end
	endtask

	// compare on every clk_en edge since clk_en still holds its sampled value at +1
	initial begin
		logic [eg_pkg::EG_W-1:0] e_out;
		logic                    e_zero, e_pg;
		int                      e_slot, p_slot;
		forever begin
			@(posedge clk);
			#1;
			if (!reset && clk_en) begin
				if (q_out.size() == 0 || q_pg.size() == 0) begin
					errors++;
					$display("output edge with nothing expected at %0t", $time);
				end else begin
					e_out  = q_out.pop_front();
					e_zero = q_zero.pop_front();
					e_slot = q_slot.pop_front();
					e_pg   = q_pg.pop_front();
					p_slot = q_pg_slot.pop_front();
					check_level("eg_out", e_slot, eg_out, e_out);
					check_strobe("out_zero", e_slot, out_zero, e_zero);
					check_strobe("pg_rst", p_slot, pg_rst, e_pg);
					if (pg_rst) pg_count++;
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////
	task automatic set_slot(input int s, input int key, input int ar, input int d1,
			input int d2, input int rr, input int slv, input int kc, input int k, input int t);
		s_key[s] = 1'(key);
		s_ar[s]  = 5'(ar);
		s_d1[s]  = 5'(d1);
		s_d2[s]  = 5'(d2);
		s_rr[s]  = 4'(rr);
		s_sl[s]  = 4'(slv);
		s_kc[s]  = 5'(kc);
		s_ks[s]  = 2'(k);
		s_tl[s]  = 7'(t);
	endtask

	task automatic apply_reset();
		@(posedge clk);
		#2;
		reset  = 1'b1;
		clk_en = 1'b0;
		zero   = 1'b0;
		repeat (4) @(posedge clk);
		#2;
		reset = 1'b0;
		for (int s = 0; s < NUM_SLOTS; s++) begin
			m_phase[s] = eg_pkg::PH_RELEASE;
			m_level[s] = 1023;
			m_key[s]   = 1'b0;
		end
		m_cnt = '0;
		q_out = {eg_pkg::EG_MAX, eg_pkg::EG_MAX};	// pipeline still holding reset values
		q_zero = {1'b0, 1'b0};
		q_slot = {-1, -1};
		q_pg.delete();
		q_pg_slot.delete();
		en_phase = 0;
	endtask

	// one slot per clk_en cycle with every third cycle idle
	task automatic send_slot(input int s);
		logic                    e_pg;
		logic [eg_pkg::EG_W-1:0] e_out;
		@(posedge clk);
		#2;
		if (en_phase == 2) begin
			clk_en   = 1'b0;
			en_phase = 0;
			@(posedge clk);
			#2;
		end
		en_phase++;
		clk_en  = 1'b1;
		zero    = (s == 0);
		keyon   = s_key[s];
		arate   = s_ar[s];
		d1rate  = s_d1[s];
		d2rate  = s_d2[s];
		rrate   = s_rr[s];
		sl      = s_sl[s];
		keycode = s_kc[s];
		ks      = s_ks[s];
		tl      = s_tl[s];
		e_out   = ref_eval(s, e_pg);
		q_out.push_back(e_out);
		q_zero.push_back(s == 0);
		q_slot.push_back(s);
		q_pg.push_back(e_pg);
		q_pg_slot.push_back(s);
	endtask

	task automatic run_sweeps(input int n);
		for (int i = 0; i < n; i++) begin
			for (int s = 0; s < NUM_SLOTS; s++) send_slot(s);
		end
	endtask

	// stop clk_en and let the compare side catch up
	task automatic end_burst();
		int cycles;
		@(posedge clk);
		#2;
		clk_en = 1'b0;
		zero   = 1'b0;
		cycles = 0;
		while (q_pg.size() != 0 || q_out.size() > 2) begin
			@(posedge clk);
			cycles++;
			if (cycles > 20) begin
				$display("timeout: compare process did not drain expected values");
				$display("Done: errors found");
				$finish;
			end
		end
	endtask

	task automatic test_result(input string name, input int err_before);
		if (errors == err_before) $display("%s: ok", name);
		else $display("%s: FAILED with %0d errors", name, errors - err_before);
	endtask

	//////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////
	initial begin
		int e0, pg0;
		void'($urandom(32'ha731));
		reset   = 1'b1;
		clk_en  = 1'b0;
		zero    = 1'b0;
		keyon   = 1'b0;
		arate   = '0;
		d1rate  = '0;
		d2rate  = '0;
		rrate   = '0;
		sl      = '0;
		keycode = '0;
		ks      = '0;
		tl      = '0;
		errors   = 0;
		checks   = 0;
		pg_count = 0;
		for (int s = 0; s < NUM_SLOTS; s++) set_slot(s, 0, 0, 0, 0, 0, 0, 0, 0, 0);
		apply_reset();

		e0 = errors;	// idle slots sit at silence
		run_sweeps(3);
		end_burst();
		test_result("reset state", e0);

		e0  = errors;	// instant attack with a tl offset
		pg0 = pg_count;
		for (int s = 0; s < NUM_SLOTS; s++) set_slot(s, 1, 31, 0, 0, 0, 0, 0, 0, s * 25);
		run_sweeps(3);
		end_burst();
		if (pg_count - pg0 != NUM_SLOTS) begin
			errors++;
			$display("pg_rst pulsed %0d times for %0d key-on edges", pg_count - pg0, NUM_SLOTS);
		end
		test_result("instant attack", e0);

		e0 = errors;	// full attack then decay then sustain
		apply_reset();
		for (int s = 0; s < NUM_SLOTS; s++) begin
			set_slot(s, 1, $urandom_range(30, 22), $urandom_range(31, 24), $urandom_range(7, 0),
				0, $urandom_range(8, 1), $urandom_range(31, 0), $urandom_range(3, 0),
				$urandom_range(15, 0));
		end
		run_sweeps(450);
		end_burst();
		for (int s = 0; s < NUM_SLOTS; s++) begin
			if (m_phase[s] != eg_pkg::PH_SUSTAIN) begin
				errors++;
				$display("slot %0d never reached sustain", s);
			end
		end
		test_result("attack decay sustain", e0);

		e0 = errors;	// release to silence where high tl clips
		for (int s = 0; s < NUM_SLOTS; s++) begin
			s_key[s] = 1'b0;
			s_rr[s]  = 4'($urandom_range(15, 11));
			s_tl[s]  = 7'(s * 20);
		end
		run_sweeps(1100);
		end_burst();
		for (int s = 0; s < NUM_SLOTS; s++) begin
			if (m_level[s] != 1023) begin
				errors++;
				$display("slot %0d did not reach silence in release", s);
			end
		end
		test_result("release", e0);

		e0 = errors;	// same decay rate with keycode and ks varied
		apply_reset();
		set_slot(0, 1, 31, 10, 0, 0, 15, 0, 0, 0);
		set_slot(1, 1, 31, 10, 0, 0, 15, 31, 0, 0);
		set_slot(2, 1, 31, 10, 0, 0, 15, 31, 3, 0);
		set_slot(3, 1, 31, 10, 0, 0, 15, 16, 2, 0);
		set_slot(4, 1, 31, 10, 0, 0, 15, 8, 1, 0);
		set_slot(5, 1, 31, 10, 0, 0, 15, 31, 1, 0);
		run_sweeps(300);
		end_burst();
		test_result("key scaling", e0);

		e0 = errors;	// random key traffic on all slots
		for (int i = 0; i < 600; i++) begin
			for (int s = 0; s < NUM_SLOTS; s++) begin
				if ($urandom_range(7, 0) == 0) begin
					set_slot(s, !s_key[s], $urandom_range(31, 0), $urandom_range(31, 0),
						$urandom_range(31, 0), $urandom_range(15, 0), $urandom_range(15, 0),
						$urandom_range(31, 0), $urandom_range(3, 0), $urandom_range(127, 0));
				end
			end
			run_sweeps(1);
		end
		end_burst();
		test_result("random keys", e0);

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

//--- verilog/eg_attenuate.sv
// stage III: total level added to the envelope, saturated and registered
module eg_attenuate (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    clk_en,
	input  logic                    zero_iii,
	input  logic [eg_pkg::EG_W-1:0] level_iii,
	input  logic [6:0]              tl_iii,
	output logic [eg_pkg::EG_W-1:0] eg_out,
	output logic                    out_zero
);

	logic [eg_pkg::EG_W:0]   sum;	// one spare bit for overflow
	logic [eg_pkg::EG_W-1:0] sat;

	//////////////////////////////////////////////////
	// tl scaling and clamp
	//////////////////////////////////////////////////

	// tl step is 8 level units
	assign sum = {1'b0, level_iii} + {1'b0, tl_iii, 3'd0};

	always_comb begin
		if (sum > {1'b0, eg_pkg::EG_MAX}) begin
			sat = eg_pkg::EG_MAX;	// clip at silence
		end else begin
			sat = sum[eg_pkg::EG_W-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			eg_out   <= eg_pkg::EG_MAX;
			out_zero <= 1'b0;
		end else if (clk_en) begin
			eg_out   <= sat;
			out_zero <= zero_iii;	// marks slot 0 at the output
		end
	end

endmodule

//--- verilog/eg_counter.sv
// global envelope time base, one tick per full sweep of the slots
module eg_counter #(
	parameter int NUM_SLOTS = 6
) (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     clk_en,
	input  logic                     zero,
	output logic [eg_pkg::CNT_W-1:0] eg_cnt
);

	localparam int SLOT_W = (NUM_SLOTS > 1) ? $clog2(NUM_SLOTS) : 1;

	logic [SLOT_W-1:0] slot_pos;	// expected slot index this cycle
	logic              synced;	// first zero seen

	always_ff @(posedge clk) begin
		if (reset) begin
			eg_cnt   <= '0;
			slot_pos <= '0;
			synced   <= 1'b0;
		end else if (clk_en) begin
			if (zero) begin
				eg_cnt   <= eg_cnt + 1'b1;	// wraps at CNT_W
				slot_pos <= SLOT_W'(1);
				synced   <= 1'b1;
			end else if (slot_pos == SLOT_W'(NUM_SLOTS - 1)) begin
				slot_pos <= '0;
			end else begin
				slot_pos <= slot_pos + 1'b1;
			end
		end
	end

	// zero must come exactly on slot 0 of every sweep, never in between
	zero_period_chk: assert property (@(posedge clk) disable iff (reset)
		(clk_en && synced) |-> (zero == (slot_pos == '0)));

endmodule

//--- verilog/eg_phase_ctrl.sv
// stage I: key edges, phase transitions and base rate selection per slot
module eg_phase_ctrl (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    clk_en,
	input  logic                    keyon,
	input  logic                    last_keyon,
	input  eg_pkg::eg_phase_t       phase_in,
	input  logic [eg_pkg::EG_W-1:0] level_in,
	input  logic [4:0]              arate,
	input  logic [4:0]              d1rate,
	input  logic [4:0]              d2rate,
	input  logic [3:0]              rrate,
	input  logic [3:0]              sl,
	input  logic [4:0]              keycode,
	input  logic [1:0]              ks,
	input  logic [6:0]              tl,
	output eg_pkg::eg_phase_t       phase_ii,
	output logic [eg_pkg::EG_W-1:0] level_ii,
	output logic [4:0]              base_rate_ii,
	output logic [4:0]              keycode_ii,
	output logic [1:0]              ks_ii,
	output logic [6:0]              tl_ii,
	output logic                    pg_rst
);

	logic                    keyon_edge;
	logic                    keyoff_edge;
	logic [eg_pkg::EG_W-1:0] sl_level;
	eg_pkg::eg_phase_t       phase_new;
	logic [eg_pkg::EG_W-1:0] level_new;
	logic [4:0]              base_rate;

	assign keyon_edge  = keyon && !last_keyon;
	assign keyoff_edge = !keyon && last_keyon;

	// sl counts in steps of 32, top code means silent
	assign sl_level = (sl == 4'hf) ? eg_pkg::EG_MAX : {1'b0, sl, 5'd0};

	//////////////////////////////////////////////////
	// phase transition
	//////////////////////////////////////////////////
	always_comb begin
		phase_new = phase_in;
		level_new = level_in;
		if (keyon_edge) begin
			phase_new = eg_pkg::PH_ATTACK;
			if (arate == 5'd31) begin
				level_new = '0;	// instant attack
			end
		end else if (keyoff_edge) begin
			phase_new = eg_pkg::PH_RELEASE;
		end else begin
			case (phase_in)
				eg_pkg::PH_ATTACK: begin
					if (level_in == '0) phase_new = eg_pkg::PH_DECAY;
				end
				eg_pkg::PH_DECAY: begin
					if (level_in >= sl_level) phase_new = eg_pkg::PH_SUSTAIN;
				end
				default: ;	// sustain and release hold until a key edge
			endcase
		end
	end

	// rate for the phase this slot is entering
	always_comb begin
		case (phase_new)
			eg_pkg::PH_ATTACK:  base_rate = arate;
			eg_pkg::PH_DECAY:   base_rate = d1rate;
			eg_pkg::PH_SUSTAIN: base_rate = d2rate;
			default:            base_rate = {rrate, 1'b1};	// release, 2*rr+1
		endcase
	end

	//////////////////////////////////////////////////
	// stage II registers
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			phase_ii     <= eg_pkg::PH_RELEASE;
			level_ii     <= eg_pkg::EG_MAX;
			base_rate_ii <= '0;	// no stepping
			keycode_ii   <= '0;
			ks_ii        <= '0;
			tl_ii        <= '0;
			pg_rst       <= 1'b0;
		end else if (clk_en) begin
			phase_ii     <= phase_new;
			level_ii     <= level_new;
			base_rate_ii <= base_rate;
			keycode_ii   <= keycode;
			ks_ii        <= ks;
			tl_ii        <= tl;
			pg_rst       <= keyon_edge;	// phase generator restarts with attack
		end
	end

endmodule

//--- verilog/eg_pkg.sv
// envelope generator package: widths, level limits, phase encoding, rate and step rules
`ifndef EG_PKG_SV
`define EG_PKG_SV

package eg_pkg;

	//////////////////////////////////////////////////
	// widths and limits
	//////////////////////////////////////////////////
	localparam int EG_W   = 10;	// attenuation, 0 = loudest
	localparam int RATE_W = 6;	// effective rate 0..63
	localparam int CNT_W  = 15;	// global envelope counter

	localparam logic [EG_W-1:0] EG_MAX = 10'd1023;	// silent

	// envelope phases, two bits so they fit the ring directly
	typedef enum logic [1:0] {
		PH_ATTACK  = 2'd0,
		PH_DECAY   = 2'd1,
		PH_SUSTAIN = 2'd2,
		PH_RELEASE = 2'd3
	} eg_phase_t;

	//////////////////////////////////////////////////
	// rate rules
	//////////////////////////////////////////////////

	// twice the base rate plus scaled keycode, rate 0 means frozen
	function automatic logic [RATE_W-1:0] eg_eff_rate(
		input logic [4:0] base,
		input logic [4:0] keycode,
		input logic [1:0] ks
	);
		logic [6:0] sum;	// up to 62 + 31
		if (base == 5'd0) begin
			return '0;
		end
		sum = {1'b0, base, 1'b0} + 7'(keycode >> (2'd3 - ks));
		return (sum > 7'd63) ? 6'd63 : sum[5:0];	// clamp
	endfunction

	// step allowed when the counter's low bits are all clear
	function automatic logic eg_step_due(
		input logic [RATE_W-1:0] rate,
		input logic [CNT_W-1:0]  cnt
	);
		int               nbits;
		logic [CNT_W-1:0] mask;
		nbits = 11 - int'(rate >> 2);
		if (nbits < 0) begin
			nbits = 0;	// fast rates step every sweep
		end
		mask = CNT_W'((32'd1 << nbits) - 32'd1);
		return (rate != '0) && ((cnt & mask) == '0);
	endfunction

endpackage

`endif

//--- verilog/eg_slot_ring.sv
// per-slot delay ring, shifts on clk_en, loads a fixed value on reset
module eg_slot_ring #(
	parameter int               WIDTH     = 1,
	parameter int               STAGES    = 6,
	parameter logic [WIDTH-1:0] RESET_VAL = '0
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             clk_en,
	input  logic [WIDTH-1:0] din,
	output logic [WIDTH-1:0] dout
);

	logic [WIDTH-1:0] bank [STAGES];	// bank[0] newest

	//////////////////////////////////////////////////
	// shift chain
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			// every slot starts from the same known value
			for (int i = 0; i < STAGES; i++) begin
				bank[i] <= RESET_VAL;
			end
		end else if (clk_en) begin
			bank[0] <= din;
			for (int i = 1; i < STAGES; i++) begin
				bank[i] <= bank[i-1];
			end
		end
	end

	assign dout = bank[STAGES-1];	// oldest word

	// a word comes back after STAGES clk_en cycles, unchanged
	//
	// used for phase, level and last keyon, each with its own depth
	// to line the returned value up with the slot now at stage I

endmodule

//--- verilog/eg_step.sv
// second pipeline stage that computes the key-scaled rate, the step decision and the new level
module eg_step (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     clk_en,
	input  eg_pkg::eg_phase_t        phase_ii,
	input  logic [eg_pkg::EG_W-1:0]  level_ii,
	input  logic [4:0]               base_rate_ii,
	input  logic [4:0]               keycode_ii,
	input  logic [1:0]               ks_ii,
	input  logic [6:0]               tl_ii,
	input  logic [eg_pkg::CNT_W-1:0] eg_cnt,
	output logic [eg_pkg::EG_W-1:0]  level_next,
	output eg_pkg::eg_phase_t        phase_next,
	output logic [eg_pkg::EG_W-1:0]  level_iii,
	output logic [6:0]               tl_iii
);

	logic [eg_pkg::RATE_W-1:0] eff_rate;
	logic                      step;
	logic [eg_pkg::EG_W-1:0]   att_dec;	// attack decrement
	logic [eg_pkg::EG_W-1:0]   att_level;
	logic [eg_pkg::EG_W-1:0]   rise_level;

	//////////////////////////////////////////////////
	// rate and step decision
	//////////////////////////////////////////////////
	assign eff_rate = eg_pkg::eg_eff_rate(base_rate_ii, keycode_ii, ks_ii);
	assign step     = eg_pkg::eg_step_due(eff_rate, eg_cnt);

	// attack is exponential with big jumps while quiet and small ones near 0
	assign att_dec = (level_ii >> 4) + 1'b1;

	always_comb begin
		if (level_ii > att_dec) begin
			att_level = level_ii - att_dec;
		end else begin
			att_level = '0;	// lands on 0 instead of wrapping
		end
	end

	// decay, sustain and release climb linearly toward silence
	assign rise_level = (level_ii == eg_pkg::EG_MAX) ? eg_pkg::EG_MAX
	                                                 : level_ii + 1'b1;

	//////////////////////////////////////////////////
	// level update
	//////////////////////////////////////////////////
	always_comb begin
		level_next = level_ii;
		if (step) begin
			if (phase_ii == eg_pkg::PH_ATTACK) begin
				level_next = att_level;
			end else begin
				level_next = rise_level;
			end
		end
	end

	// transitions happen in stage I on the next sweep
	assign phase_next = phase_ii;

	always_ff @(posedge clk) begin
		if (reset) begin
			level_iii <= eg_pkg::EG_MAX;
			tl_iii    <= '0;
		end else if (clk_en) begin
			level_iii <= level_next;
			tl_iii    <= tl_ii;
		end
	end

	// a zero base rate freezes the level whatever keycode and ks add
	level_frozen_chk: assert property (@(posedge clk) disable iff (reset)
		(clk_en && base_rate_ii == '0) |=> (level_iii == $past(level_ii)));

endmodule

//--- verilog/eg_top.sv
// envelope generator top: counter, per-slot rings and the three pipeline stages
module eg_top #(
	parameter int NUM_SLOTS = 6
) (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    clk_en,
	input  logic                    zero,
	input  logic                    keyon,
	input  logic [4:0]              arate,
	input  logic [4:0]              d1rate,
	input  logic [4:0]              d2rate,
	input  logic [3:0]              rrate,
	input  logic [3:0]              sl,
	input  logic [4:0]              keycode,
	input  logic [1:0]              ks,
	input  logic [6:0]              tl,
	output logic [eg_pkg::EG_W-1:0] eg_out,
	output logic                    out_zero,
	output logic                    pg_rst
);

	logic [eg_pkg::CNT_W-1:0] eg_cnt;
	logic                     last_keyon;
	logic [1:0]               phase_ring;
	eg_pkg::eg_phase_t        phase_in, phase_ii, phase_next;
	logic [eg_pkg::EG_W-1:0]  level_in, level_ii, level_next, level_iii;
	logic [4:0]               base_rate_ii, keycode_ii;
	logic [1:0]               ks_ii;
	logic [6:0]               tl_ii, tl_iii;
	logic                     zero_ii, zero_iii;

	eg_counter #(.NUM_SLOTS(NUM_SLOTS)) u_counter (
		.clk(clk), .reset(reset), .clk_en(clk_en), .zero(zero), .eg_cnt(eg_cnt));

	//////////////////////////////////////////////////
	// per-slot state rings
	//////////////////////////////////////////////////
	// keyon enters at stage I, phase and level return from stage II one edge later
	eg_slot_ring #(.WIDTH(1), .STAGES(NUM_SLOTS), .RESET_VAL(1'b0)) u_keyon_ring (
		.clk(clk), .reset(reset), .clk_en(clk_en), .din(keyon), .dout(last_keyon));

	eg_slot_ring #(.WIDTH(2), .STAGES(NUM_SLOTS - 1), .RESET_VAL(eg_pkg::PH_RELEASE))
	u_phase_ring (
		.clk(clk), .reset(reset), .clk_en(clk_en), .din(phase_next), .dout(phase_ring));

	assign phase_in = eg_pkg::eg_phase_t'(phase_ring);

	eg_slot_ring #(.WIDTH(eg_pkg::EG_W), .STAGES(NUM_SLOTS - 1), .RESET_VAL(eg_pkg::EG_MAX))
	u_level_ring (
		.clk(clk), .reset(reset), .clk_en(clk_en), .din(level_next), .dout(level_in));

	//////////////////////////////////////////////////
	// pipeline stages
	//////////////////////////////////////////////////
	eg_phase_ctrl u_phase_ctrl (
		.clk(clk), .reset(reset), .clk_en(clk_en), .keyon(keyon), .last_keyon(last_keyon),
		.phase_in(phase_in), .level_in(level_in), .arate(arate), .d1rate(d1rate),
		.d2rate(d2rate), .rrate(rrate), .sl(sl), .keycode(keycode), .ks(ks), .tl(tl),
		.phase_ii(phase_ii), .level_ii(level_ii), .base_rate_ii(base_rate_ii),
		.keycode_ii(keycode_ii), .ks_ii(ks_ii), .tl_ii(tl_ii), .pg_rst(pg_rst));

	eg_step u_step (
		.clk(clk), .reset(reset), .clk_en(clk_en), .phase_ii(phase_ii), .level_ii(level_ii),
		.base_rate_ii(base_rate_ii), .keycode_ii(keycode_ii), .ks_ii(ks_ii), .tl_ii(tl_ii),
		.eg_cnt(eg_cnt), .level_next(level_next), .phase_next(phase_next),
		.level_iii(level_iii), .tl_iii(tl_iii));

	// zero follows the slot data down to stage III
	always_ff @(posedge clk) begin
		if (reset) begin
			zero_ii  <= 1'b0;
			zero_iii <= 1'b0;
		end else if (clk_en) begin
			zero_ii  <= zero;
			zero_iii <= zero_ii;
		end
	end

	eg_attenuate u_attenuate (
		.clk(clk), .reset(reset), .clk_en(clk_en), .zero_iii(zero_iii),
		.level_iii(level_iii), .tl_iii(tl_iii), .eg_out(eg_out), .out_zero(out_zero));

endmodule
